/* common/vchess_pkg.sv */
`default_nettype none

package vchess_pkg;

   localparam int PIECE_WIDTH  = 4;
   localparam int RANK_WIDTH   = 8 * PIECE_WIDTH;    // Eight squares per rank
   localparam int BOARD_WIDTH  = 8 * RANK_WIDTH;     // 64 squares
   localparam int STATUS_WIDTH = 32;

   // Rank in [5:3], file in [2:0], square 0 is a1
   typedef logic [5:0] square_t;

   // Bit 3 is the colour, black when set
   typedef enum logic [PIECE_WIDTH-1:0] {
      EMPTY      = 4'h0,
      WHITE_PAWN = 4'h1,
      WHITE_KNIT = 4'h2,
      WHITE_BISH = 4'h3,
      WHITE_ROOK = 4'h4,
      WHITE_QUEN = 4'h5,
      WHITE_KING = 4'h6,
      BLACK_PAWN = 4'h9,
      BLACK_KNIT = 4'hA,
      BLACK_BISH = 4'hB,
      BLACK_ROOK = 4'hC,
      BLACK_QUEN = 4'hD,
      BLACK_KING = 4'hE
   } piece_e;

   typedef enum logic {
      RD_STATUS = 1'b0,
      RD_SQUARE = 1'b1
   } rd_sel_e;

   // Ranks are written file 7 first, so file 0 lands in the low bits
   localparam logic [RANK_WIDTH-1:0] WHITE_BACK_RANK = {
      WHITE_ROOK, WHITE_KNIT, WHITE_BISH, WHITE_KING,
      WHITE_QUEN, WHITE_BISH, WHITE_KNIT, WHITE_ROOK};
   localparam logic [RANK_WIDTH-1:0] BLACK_BACK_RANK = {
      BLACK_ROOK, BLACK_KNIT, BLACK_BISH, BLACK_KING,
      BLACK_QUEN, BLACK_BISH, BLACK_KNIT, BLACK_ROOK};
   localparam logic [RANK_WIDTH-1:0] WHITE_PAWN_RANK = {8{WHITE_PAWN}};
   localparam logic [RANK_WIDTH-1:0] BLACK_PAWN_RANK = {8{BLACK_PAWN}};
   localparam logic [RANK_WIDTH-1:0] EMPTY_RANK      = {8{EMPTY}};

   // Standard opening position, rank 7 in the top bits
   localparam logic [BOARD_WIDTH-1:0] START_BOARD = {
      BLACK_BACK_RANK, BLACK_PAWN_RANK,
      EMPTY_RANK, EMPTY_RANK, EMPTY_RANK, EMPTY_RANK,
      WHITE_PAWN_RANK, WHITE_BACK_RANK};

endpackage

`default_nettype wire

/* src/status_sync.sv */
`timescale 1ns/100ps
`default_nettype none

module status_sync
   import vchess_pkg::*;
#(
   parameter int SYNC_STAGES = 2,
   parameter int COUNT_WIDTH = 16
)
(
   input  wire                      c0_ddr4_ui_clk,
   input  wire                      rst_n,
   input  wire                      calib_complete,   // Async level from memory controller
   input  wire                      mem_rst,          // Async level from memory controller
   output logic [STATUS_WIDTH-1:0]  misc_status,
   output logic                     random_bit
);

   localparam int CNT_FIELD = STATUS_WIDTH - 16;    // Counter lives in the upper half

   logic [SYNC_STAGES-1:0] calib_sync;
   logic [SYNC_STAGES-1:0] mem_rst_sync;
   logic [COUNT_WIDTH-1:0] cycle_count;
   logic [CNT_FIELD-1:0]   count_field;

   always_ff @(posedge c0_ddr4_ui_clk)
   begin
      if (!rst_n)
      begin
         calib_sync   <= '0;
         mem_rst_sync <= '0;
         cycle_count  <= '0;
      end
      else
      begin
         calib_sync   <= {calib_sync[SYNC_STAGES-2:0], calib_complete};
         mem_rst_sync <= {mem_rst_sync[SYNC_STAGES-2:0], mem_rst};
         cycle_count  <= cycle_count + 1'b1;               // Free running, wraps
      end
   end

   assign count_field = CNT_FIELD'(cycle_count);
   assign misc_status = {count_field, 14'b0, mem_rst_sync[SYNC_STAGES-1],
                         calib_sync[SYNC_STAGES-1]};
   assign random_bit  = cycle_count[0];                    // Toggles every cycle

   a_count_step : assert property (@(posedge c0_ddr4_ui_clk) disable iff (!rst_n)
      $past(rst_n) |-> cycle_count == COUNT_WIDTH'($past(cycle_count) + 1'b1))
      else $error("status_sync: cycle counter did not advance by one");

endmodule

`default_nettype wire

/* board/board_loader.sv */
`timescale 1ns/100ps
`default_nettype none

module board_loader
   import vchess_pkg::*;
(
   input  wire                     c0_ddr4_ui_clk,
   input  wire                     rst_n,
   input  wire                     new_board_valid,  // Level or strobe from host
   input  wire [BOARD_WIDTH-1:0]   new_board,
   output logic [BOARD_WIDTH-1:0]  board_out,
   output logic                    board_valid       // One cycle after a load
);

   logic new_board_valid_z;   // Strobe from the previous cycle
   logic load_edge;

   // Rising edge only, so a held strobe loads once
   assign load_edge = new_board_valid & ~new_board_valid_z;

   always_ff @(posedge c0_ddr4_ui_clk)
   begin
      if (!rst_n)
      begin
         new_board_valid_z <= 1'b1;   // Needs a fresh low-to-high after reset
         board_valid       <= 1'b0;
      end
      else
      begin
         new_board_valid_z <= new_board_valid;
         board_valid       <= load_edge;
      end
   end

   // Position register, comes out of reset holding the opening
   always_ff @(posedge c0_ddr4_ui_clk)
   begin
      if (!rst_n)
      begin
         board_out <= START_BOARD;
      end
      else if (load_edge)
      begin
         board_out <= new_board;
      end
   end

   // Never two load pulses back to back
   a_valid_single : assert property (@(posedge c0_ddr4_ui_clk) disable iff (!rst_n)
      board_valid |=> !board_valid)
      else $error("board_loader: board_valid high in two consecutive cycles");

   // A pulse needs the strobe low two cycles back and high one cycle back,
   // and the board then matches what the host presented
   a_valid_after_edge : assert property (@(posedge c0_ddr4_ui_clk) disable iff (!rst_n)
      board_valid |-> $past(new_board_valid) && !$past(new_board_valid, 2)
                      && board_out == $past(new_board))
      else $error("board_loader: board_valid without a preceding rising edge");

endmodule

`default_nettype wire

/* src/reg_read.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_read
   import vchess_pkg::*;
(
   input  wire                      c0_ddr4_ui_clk,
   input  wire                      rst_n,
   input  wire                      rd_en,        // One-cycle read strobe
   input  wire rd_sel_e             rd_sel,
   input  wire square_t             rd_square,
   input  wire [STATUS_WIDTH-1:0]   misc_status,
   input  wire [BOARD_WIDTH-1:0]    board_out,
   output logic [STATUS_WIDTH-1:0]  rd_data,
   output logic                     rd_valid
);

   logic [PIECE_WIDTH-1:0]  square_code;
   logic [STATUS_WIDTH-1:0] rd_mux;

   // Square index times four gives the bit offset
   assign square_code = board_out[rd_square * PIECE_WIDTH +: PIECE_WIDTH];

   always_comb
   begin
      case (rd_sel)
         RD_SQUARE : rd_mux = STATUS_WIDTH'(square_code);   // Zero extended
         default   : rd_mux = misc_status;
      endcase
   end

   always_ff @(posedge c0_ddr4_ui_clk)
   begin
      if (!rst_n)
      begin
         rd_valid <= 1'b0;
      end
      else
      begin
         rd_valid <= rd_en;
      end
   end

   // Read data only moves when a read is issued
   always_ff @(posedge c0_ddr4_ui_clk)
   begin
      if (rd_en)
      begin
         rd_data <= rd_mux;
      end
   end

   a_rd_latency : assert property (@(posedge c0_ddr4_ui_clk) disable iff (!rst_n)
      $past(rst_n) |-> rd_valid == $past(rd_en))
      else $error("reg_read: rd_valid is not rd_en delayed by one cycle");

endmodule

`default_nettype wire

/* src/vchess_top.sv */
`timescale 1ns/100ps
`default_nettype none

module vchess_top
   import vchess_pkg::*;
#(
   parameter int SYNC_STAGES = 2,
   parameter int COUNT_WIDTH = 16
)
(
   input  wire                      c0_ddr4_ui_clk,
   input  wire                      rst_n,
   input  wire                      calib_complete,
   input  wire                      mem_rst,
   input  wire                      new_board_valid,
   input  wire [BOARD_WIDTH-1:0]    new_board,
   input  wire                      rd_en,
   input  wire rd_sel_e             rd_sel,
   input  wire square_t             rd_square,
   output logic [BOARD_WIDTH-1:0]   board_out,
   output logic                     board_valid,
   output logic                     random_bit,
   output logic [STATUS_WIDTH-1:0]  rd_data,
   output logic                     rd_valid
);

   logic [STATUS_WIDTH-1:0] misc_status;   // Counter and synced status levels

   status_sync #(
      .SYNC_STAGES (SYNC_STAGES),
      .COUNT_WIDTH (COUNT_WIDTH)
   ) u_status_sync (
      .c0_ddr4_ui_clk (c0_ddr4_ui_clk),
      .rst_n          (rst_n),
      .calib_complete (calib_complete),
      .mem_rst        (mem_rst),
      .misc_status    (misc_status),
      .random_bit     (random_bit)
   );

   board_loader u_board_loader (
      .c0_ddr4_ui_clk  (c0_ddr4_ui_clk),
      .rst_n           (rst_n),
      .new_board_valid (new_board_valid),
      .new_board       (new_board),
      .board_out       (board_out),
      .board_valid     (board_valid)
   );

   reg_read u_reg_read (
      .c0_ddr4_ui_clk (c0_ddr4_ui_clk),
      .rst_n          (rst_n),
      .rd_en          (rd_en),
      .rd_sel         (rd_sel),
      .rd_square      (rd_square),
      .misc_status    (misc_status),
      .board_out      (board_out),
      .rd_data        (rd_data),
      .rd_valid       (rd_valid)
   );

endmodule

`default_nettype wire

/* verification/tb_vchess_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_vchess_top
   import vchess_pkg::*;
();

   localparam int SYNC_STAGES    = 2;
   localparam int COUNT_WIDTH    = 16;
   localparam int TIMEOUT_CYCLES = 600;   // About twice the stimulus length

   logic                    c0_ddr4_ui_clk;
   logic                    rst_n;
   logic                    calib_complete;
   logic                    mem_rst;
   logic                    new_board_valid;
   logic [BOARD_WIDTH-1:0]  new_board;
   logic                    rd_en;
   rd_sel_e                 rd_sel;
   square_t                 rd_square;
   logic [BOARD_WIDTH-1:0]  board_out;
   logic                    board_valid;
   logic                    random_bit;
   logic [STATUS_WIDTH-1:0] rd_data;
   logic                    rd_valid;

   logic                    checks_on;         // Set one cycle after reset release
   logic [BOARD_WIDTH-1:0]  model_board;
   logic                    model_prev_valid;
   logic                    exp_pulse;
   logic [COUNT_WIDTH-1:0]  model_count;
   logic [SYNC_STAGES-1:0]  calib_dly;
   logic [SYNC_STAGES-1:0]  mem_dly;
   logic                    exp_rd_valid;
   logic [STATUS_WIDTH-1:0] exp_rd_data;
   logic                    exp_status_read;
   logic [31:0]             lfsr_state;
   int                      cycle_count;
   int                      mismatch_count;
   int                      other_count;
   int                      i;
   logic [BOARD_WIDTH-1:0]  board_a;
   logic [BOARD_WIDTH-1:0]  board_b;
   logic [BOARD_WIDTH-1:0]  pick;

   vchess_top #(
      .SYNC_STAGES (SYNC_STAGES),
      .COUNT_WIDTH (COUNT_WIDTH)
   ) u_dut (
      .c0_ddr4_ui_clk  (c0_ddr4_ui_clk),
      .rst_n           (rst_n),
      .calib_complete  (calib_complete),
      .mem_rst         (mem_rst),
      .new_board_valid (new_board_valid),
      .new_board       (new_board),
      .rd_en           (rd_en),
      .rd_sel          (rd_sel),
      .rd_square       (rd_square),
      .board_out       (board_out),
      .board_valid     (board_valid),
      .random_bit      (random_bit),
      .rd_data         (rd_data),
      .rd_valid        (rd_valid)
   );

   initial c0_ddr4_ui_clk = 1'b0;
   always #20 c0_ddr4_ui_clk = ~c0_ddr4_ui_clk;   // 40 ns period

   // Opening position placed square by square at index rank * 8 + file
   function automatic logic [BOARD_WIDTH-1:0] opening_board();
      logic [BOARD_WIDTH-1:0] b;
      piece_e                 white_back [8];
      piece_e                 black_back [8];
      int                     f;
      b = {64{EMPTY}};
      white_back = '{WHITE_ROOK, WHITE_KNIT, WHITE_BISH, WHITE_QUEN,
                     WHITE_KING, WHITE_BISH, WHITE_KNIT, WHITE_ROOK};
      black_back = '{BLACK_ROOK, BLACK_KNIT, BLACK_BISH, BLACK_QUEN,
                     BLACK_KING, BLACK_BISH, BLACK_KNIT, BLACK_ROOK};
      for (f = 0; f < 8; f++)
      begin
         b[(0 * 8 + f) * PIECE_WIDTH +: PIECE_WIDTH] = white_back[f];
         b[(1 * 8 + f) * PIECE_WIDTH +: PIECE_WIDTH] = WHITE_PAWN;
         b[(6 * 8 + f) * PIECE_WIDTH +: PIECE_WIDTH] = BLACK_PAWN;
         b[(7 * 8 + f) * PIECE_WIDTH +: PIECE_WIDTH] = black_back[f];
      end
      return b;
   endfunction

   function automatic logic [STATUS_WIDTH-1:0] status_word(input logic [COUNT_WIDTH-1:0] count,
                                                           input logic mem, input logic calib);
      logic [STATUS_WIDTH-1:0] word;
      word = '0;
      word[16 +: COUNT_WIDTH] = count;
      word[1] = mem;
      word[0] = calib;
      return word;
   endfunction

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int count, output logic [BOARD_WIDTH-1:0] value);
      int n;
      value = '0;
      for (n = 0; n < count; n++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         value[n]   = lfsr_state[0];
      end
   endtask

   task automatic read_square(input square_t sq);
      @(posedge c0_ddr4_ui_clk);
      rd_en     <= 1'b1;
      rd_sel    <= RD_SQUARE;
      rd_square <= sq;
   endtask

   task automatic read_status();
      @(posedge c0_ddr4_ui_clk);
      rd_en  <= 1'b1;
      rd_sel <= RD_STATUS;
   endtask

   // New status levels and a status read in the same cycle
   task automatic set_status(input logic calib, input logic mem);
      @(posedge c0_ddr4_ui_clk);
      calib_complete <= calib;
      mem_rst        <= mem;
      rd_en          <= 1'b1;
      rd_sel         <= RD_STATUS;
   endtask

   task automatic idle(input int cycles);
      repeat (cycles)
      begin
         @(posedge c0_ddr4_ui_clk);
         rd_en <= 1'b0;
      end
   endtask

   // Rising edge with board a, then board b shown while the strobe stays high
   task automatic load_board(input logic [BOARD_WIDTH-1:0] a, input logic [BOARD_WIDTH-1:0] b,
                             input int hold);
      @(posedge c0_ddr4_ui_clk);
      new_board_valid <= 1'b0;
      rd_en           <= 1'b0;
      @(posedge c0_ddr4_ui_clk);
      new_board       <= a;
      new_board_valid <= 1'b1;
      @(posedge c0_ddr4_ui_clk);
      new_board       <= b;
      repeat (hold) @(posedge c0_ddr4_ui_clk);
      new_board_valid <= 1'b0;
   endtask

   // Reference model
   always @(posedge c0_ddr4_ui_clk)
   begin
      if (!rst_n)
      begin
         model_board      <= opening_board();
         model_prev_valid <= 1'b1;      // First load needs a fresh edge
         exp_pulse        <= 1'b0;
         model_count      <= '0;
         calib_dly        <= '0;
         mem_dly          <= '0;
         exp_rd_valid     <= 1'b0;
      end
      else
      begin
         model_prev_valid <= new_board_valid;
         exp_pulse        <= new_board_valid && !model_prev_valid;
         if (new_board_valid && !model_prev_valid)
         begin
            model_board <= new_board;
         end
         model_count  <= model_count + 1'b1;
         calib_dly    <= {calib_dly[SYNC_STAGES-2:0], calib_complete};
         mem_dly      <= {mem_dly[SYNC_STAGES-2:0], mem_rst};
         exp_rd_valid <= rd_en;
      end
      if (rd_en)
      begin
         exp_status_read <= (rd_sel == RD_STATUS);
         if (rd_sel == RD_SQUARE)
            exp_rd_data <= STATUS_WIDTH'(model_board[rd_square * PIECE_WIDTH +: PIECE_WIDTH]);
         else
            exp_rd_data <= status_word(model_count, mem_dly[SYNC_STAGES-1],
                                       calib_dly[SYNC_STAGES-1]);
      end
   end

   a_rd_valid : assert property (@(posedge c0_ddr4_ui_clk)
      checks_on |-> rd_valid == exp_rd_valid)
   else
   begin
      mismatch_count = mismatch_count + 1;
      $display("mismatch rd_valid: got %h expected %h", $sampled(rd_valid),
               $sampled(exp_rd_valid));
   end

   a_rd_data : assert property (@(posedge c0_ddr4_ui_clk)
      checks_on && rd_valid |-> rd_data == exp_rd_data)
   else
   begin
      mismatch_count = mismatch_count + 1;
      $display("mismatch rd_data: got %h expected %h", $sampled(rd_data),
               $sampled(exp_rd_data));
   end

   a_status_zero : assert property (@(posedge c0_ddr4_ui_clk)
      checks_on && rd_valid && exp_status_read |-> rd_data[15:2] == '0)
   else
   begin
      other_count = other_count + 1;
      $display("status word has bits set in its reserved field 15:2");
   end

   a_board_out : assert property (@(posedge c0_ddr4_ui_clk)
      checks_on |-> board_out == model_board)
   else
   begin
      mismatch_count = mismatch_count + 1;
      $display("mismatch board_out: got %h expected %h", $sampled(board_out),
               $sampled(model_board));
   end

   a_load_pulse : assert property (@(posedge c0_ddr4_ui_clk)
      checks_on && exp_pulse |-> board_valid)
   else
   begin
      other_count = other_count + 1;
      $display("board_valid pulse missing after a rising edge of new_board_valid");
   end

   a_no_extra_pulse : assert property (@(posedge c0_ddr4_ui_clk)
      checks_on && !exp_pulse |-> !board_valid)
   else
   begin
      other_count = other_count + 1;
      $display("board_valid pulsed without a rising edge of new_board_valid");
   end

   // Counter bit 0 of the model flips every cycle after reset
   a_random_bit : assert property (@(posedge c0_ddr4_ui_clk)
      checks_on |-> random_bit == model_count[0])
   else
   begin
      mismatch_count = mismatch_count + 1;
      $display("mismatch random_bit: got %h expected %h", $sampled(random_bit),
               $sampled(model_count[0]));
   end

   always @(posedge c0_ddr4_ui_clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES)
      begin
         $display("timeout after %0d cycles, the stimulus did not finish", TIMEOUT_CYCLES);
         $display("errors: %0d mismatch, %0d other", mismatch_count, other_count);
         $display("*** FAILED ***");
         $finish;
      end
   end

   initial
   begin
      rst_n           = 1'b0;
      calib_complete  = 1'b0;
      mem_rst         = 1'b0;
      new_board_valid = 1'b0;
      new_board       = '0;
      rd_en           = 1'b0;
      rd_sel          = RD_STATUS;
      rd_square       = '0;
      checks_on       = 1'b0;
      cycle_count     = 0;
      mismatch_count  = 0;
      other_count     = 0;
      lfsr_state      = 32'd87355;
      repeat (2) @(posedge c0_ddr4_ui_clk);
      rst_n <= 1'b1;
      @(posedge c0_ddr4_ui_clk);
      checks_on <= 1'b1;

      for (i = 0; i < 64; i++)
         read_square(square_t'(i));      // Back to back over the opening
      idle(2);

      take_bits(BOARD_WIDTH, board_a);
      take_bits(BOARD_WIDTH, board_b);
      load_board(board_a, board_b, 4);
      for (i = 0; i < 48; i++)
      begin
         take_bits(6, pick);
         read_square(pick[5:0]);
         take_bits(1, pick);
         if (pick[0])
            idle(1);
      end
      idle(2);

      read_status();
      idle(4);
      read_status();                      // Five cycles after the first
      idle(1);
      read_status();
      set_status(1'b1, 1'b0);
      repeat (4) read_status();
      set_status(1'b1, 1'b1);
      repeat (4) read_status();
      set_status(1'b0, 1'b1);
      repeat (4) read_status();
      set_status(1'b0, 1'b0);
      repeat (4) read_status();
      idle(2);

      take_bits(BOARD_WIDTH, board_a);
      take_bits(BOARD_WIDTH, board_b);
      load_board(board_a, board_b, 3);
      for (i = 0; i < 16; i++)
      begin
         take_bits(6, pick);
         read_square(pick[5:0]);
      end
      idle(3);

      $display("errors: %0d mismatch, %0d other", mismatch_count, other_count);
      if (mismatch_count + other_count == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* vchess_top.f */
common/vchess_pkg.sv
src/status_sync.sv
board/board_loader.sv
src/reg_read.sv
src/vchess_top.sv
verification/tb_vchess_top.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = tb_vchess_top
FILELIST = vchess_top.f

OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -F '*** FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
